// File: include/eth_mgmt_config.svh
//============================
// Ethernet management configuration
// Bus widths, register map and MDIO counter limits
//============================
`ifndef ETH_MGMT_CONFIG_SVH
`define ETH_MGMT_CONFIG_SVH

// Bus widths
`define ETH_MGMT_AXI_ADDR_W     14
`define ETH_MGMT_DATA_W         32
`define ETH_MGMT_REG_IDX_W      12

// Register word indices
`define ETH_MGMT_REG_SCRATCH0   0
`define ETH_MGMT_REG_SCRATCH1   1
`define ETH_MGMT_REG_SCRATCH2   2
`define ETH_MGMT_REG_SCRATCH3   3
`define ETH_MGMT_REG_MDIO_ADDR  4
`define ETH_MGMT_REG_MDIO_WDATA 5
`define ETH_MGMT_REG_MDIO_RDATA 6
`define ETH_MGMT_REG_MDIO_CTRL  7

// MDIO reset value and half-MDC counter limits
`define ETH_MGMT_MDIO_PHY_RST   1
`define ETH_MGMT_MDIO_CNT_FRAME 65
`define ETH_MGMT_MDIO_CNT_INIT  125
`define ETH_MGMT_MDIO_TRI_CNT   29

`endif

// File: hw/eth_mgmt_pkg.sv
//============================
// Ethernet management types
// Structs passed between bus, register and MDIO stages
//============================
`default_nettype none

`include "eth_mgmt_config.svh"

package eth_mgmt_pkg;

  typedef logic [`ETH_MGMT_REG_IDX_W-1:0] reg_idx_t;
  typedef logic [`ETH_MGMT_DATA_W-1:0]    bus_data_t;
  typedef logic [4:0]                     mdio_addr_t;
  typedef logic [15:0]                    mdio_data_t;
  typedef logic [6:0]                     mdio_cnt_t;

  // Bus slave to register file
  typedef struct packed {
    logic      wr;
    logic      rd;
    reg_idx_t  idx;
    bus_data_t wdata;
  } reg_req_t;

  typedef struct packed {
    logic      rd_done;
    bus_data_t rdata;
  } reg_rsp_t;

  // Register file to MDIO master, op 1 is a read
  typedef struct packed {
    logic       start;
    logic       op;
    mdio_addr_t phy_addr;
    mdio_addr_t reg_addr;
    mdio_data_t wdata;
  } mdio_cmd_t;

  typedef struct packed {
    logic       busy;
    logic       init;
    mdio_data_t rdata;
  } mdio_stat_t;

  typedef enum logic [1:0] {AXI_RD_IDLE, AXI_RD_REQ, AXI_RD_RESP} axi_rd_state_e;
  typedef enum logic [1:0] {AXI_WR_IDLE, AXI_WR_DATA_WAIT, AXI_WR_REQ, AXI_WR_RESP} axi_wr_state_e;

endpackage

`default_nettype wire

// File: hw/eth_mgmt_axi_slave.sv
//============================
// AXI4-Lite register slave
// Turns bus reads and writes into one-cycle register requests
//============================
`timescale 1ns/100ps
`default_nettype none

`include "eth_mgmt_config.svh"

module eth_mgmt_axi_slave (
  input  logic                             s_axi_aclk,
  input  logic                             s_axi_aresetn,
  input  logic [`ETH_MGMT_AXI_ADDR_W-1:0]  s_axi_awaddr,
  input  logic                             s_axi_awvalid,
  output logic                             s_axi_awready,
  input  logic [`ETH_MGMT_DATA_W-1:0]      s_axi_wdata,
  input  logic                             s_axi_wvalid,
  output logic                             s_axi_wready,
  output logic [1:0]                       s_axi_bresp,
  output logic                             s_axi_bvalid,
  input  logic                             s_axi_bready,
  input  logic [`ETH_MGMT_AXI_ADDR_W-1:0]  s_axi_araddr,
  input  logic                             s_axi_arvalid,
  output logic                             s_axi_arready,
  output logic [`ETH_MGMT_DATA_W-1:0]      s_axi_rdata,
  output logic [1:0]                       s_axi_rresp,
  output logic                             s_axi_rvalid,
  input  logic                             s_axi_rready,
  output eth_mgmt_pkg::reg_req_t           req_o,
  input  eth_mgmt_pkg::reg_rsp_t           rsp_i
);

  eth_mgmt_pkg::axi_rd_state_e rd_state_q;
  eth_mgmt_pkg::axi_wr_state_e wr_state_q;
  eth_mgmt_pkg::reg_idx_t      raddr_q;
  eth_mgmt_pkg::reg_idx_t      waddr_q;
  eth_mgmt_pkg::bus_data_t     wdata_q;
  logic                        rd_req_q;
  logic                        wr_done_q;
  logic                        wr_req;
  logic                        ar_hit;
  logic                        aw_hit;
  logic                        w_hit;

  assign ar_hit = s_axi_arvalid & s_axi_arready;
  assign aw_hit = s_axi_awvalid & s_axi_awready;
  assign w_hit  = s_axi_wvalid & s_axi_wready;

  // Write strobe waits one cycle if a read strobe is out
  assign wr_req = (wr_state_q == eth_mgmt_pkg::AXI_WR_REQ) & ~wr_done_q & ~rd_req_q;

  assign req_o = '{wr: wr_req, rd: rd_req_q, idx: wr_req ? waddr_q : raddr_q, wdata: wdata_q};

  // OKAY response only
  assign s_axi_bresp = 2'b00;
  assign s_axi_rresp = 2'b00;

  //============================
  // Read channel
  //============================
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      rd_state_q    <= eth_mgmt_pkg::AXI_RD_IDLE;
      rd_req_q      <= 1'b0;
      s_axi_arready <= 1'b1;
      s_axi_rvalid  <= 1'b0;
    end else begin
      rd_req_q <= ar_hit;
      case (rd_state_q)
        eth_mgmt_pkg::AXI_RD_IDLE: begin
          if (ar_hit) begin
            s_axi_arready <= 1'b0;
            rd_state_q    <= eth_mgmt_pkg::AXI_RD_REQ;
          end
        end
        eth_mgmt_pkg::AXI_RD_REQ: begin
          if (rsp_i.rd_done) begin
            s_axi_rvalid <= 1'b1;
            rd_state_q   <= eth_mgmt_pkg::AXI_RD_RESP;
          end
        end
        default: begin
          if (s_axi_rready) begin
            s_axi_rvalid  <= 1'b0;
            s_axi_arready <= 1'b1;
            rd_state_q    <= eth_mgmt_pkg::AXI_RD_IDLE;
          end
        end
      endcase
    end
  end

  //============================
  // Write channel
  //============================
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      wr_state_q    <= eth_mgmt_pkg::AXI_WR_IDLE;
      wr_done_q     <= 1'b0;
      s_axi_awready <= 1'b1;
      s_axi_wready  <= 1'b1;
      s_axi_bvalid  <= 1'b0;
    end else begin
      wr_done_q <= wr_req;
      if (aw_hit) begin
        s_axi_awready <= 1'b0;
      end
      if (w_hit) begin
        s_axi_wready <= 1'b0;
      end
      case (wr_state_q)
        eth_mgmt_pkg::AXI_WR_IDLE: begin
          // Data may arrive ahead of the address
          if (aw_hit && (w_hit || !s_axi_wready)) begin
            wr_state_q <= eth_mgmt_pkg::AXI_WR_REQ;
          end else if (aw_hit) begin
            wr_state_q <= eth_mgmt_pkg::AXI_WR_DATA_WAIT;
          end
        end
        eth_mgmt_pkg::AXI_WR_DATA_WAIT: begin
          if (w_hit) begin
            wr_state_q <= eth_mgmt_pkg::AXI_WR_REQ;
          end
        end
        eth_mgmt_pkg::AXI_WR_REQ: begin
          if (wr_done_q) begin
            s_axi_bvalid <= 1'b1;
            wr_state_q   <= eth_mgmt_pkg::AXI_WR_RESP;
          end
        end
        default: begin
          if (s_axi_bready) begin
            s_axi_bvalid  <= 1'b0;
            s_axi_awready <= 1'b1;
            s_axi_wready  <= 1'b1;
            wr_state_q    <= eth_mgmt_pkg::AXI_WR_IDLE;
          end
        end
      endcase
    end
  end

  // Captured address, data and read result
  always_ff @(posedge s_axi_aclk) begin
    if (ar_hit) begin
      raddr_q <= s_axi_araddr[`ETH_MGMT_AXI_ADDR_W-1:2];
    end
    if (aw_hit) begin
      waddr_q <= s_axi_awaddr[`ETH_MGMT_AXI_ADDR_W-1:2];
    end
    if (w_hit) begin
      wdata_q <= s_axi_wdata;
    end
    if ((rd_state_q == eth_mgmt_pkg::AXI_RD_REQ) && rsp_i.rd_done) begin
      s_axi_rdata <= rsp_i.rdata;
    end
  end

endmodule

`default_nettype wire

// File: hw/eth_mgmt_regs.sv
//============================
// Management register file
// Scratch and MDIO registers, read mux and MDIO start
//============================
`timescale 1ns/100ps
`default_nettype none

`include "eth_mgmt_config.svh"

module eth_mgmt_regs (
  input  logic                     s_axi_aclk,
  input  logic                     s_axi_aresetn,
  input  eth_mgmt_pkg::reg_req_t   req_i,
  output eth_mgmt_pkg::reg_rsp_t   rsp_o,
  output eth_mgmt_pkg::mdio_cmd_t  cmd_o,
  input  eth_mgmt_pkg::mdio_stat_t stat_i
);

  eth_mgmt_pkg::bus_data_t   scratch_q [4];
  eth_mgmt_pkg::mdio_addr_t  phy_addr_q;
  eth_mgmt_pkg::mdio_addr_t  reg_addr_q;
  eth_mgmt_pkg::mdio_data_t  mdio_wdata_q;
  eth_mgmt_pkg::bus_data_t   rd_mux;
  eth_mgmt_pkg::bus_data_t   rdata_q;
  logic                      mdio_op_q;
  logic                      mdio_en_q;
  logic                      start_q;
  logic                      rd_done_q;

  //============================
  // Read mux
  //============================
  always_comb begin
    case (req_i.idx)
      `ETH_MGMT_REG_SCRATCH0:   rd_mux = scratch_q[0];
      `ETH_MGMT_REG_SCRATCH1:   rd_mux = scratch_q[1];
      `ETH_MGMT_REG_SCRATCH2:   rd_mux = scratch_q[2];
      `ETH_MGMT_REG_SCRATCH3:   rd_mux = scratch_q[3];
      `ETH_MGMT_REG_MDIO_ADDR:  rd_mux = {21'h0, mdio_op_q, phy_addr_q, reg_addr_q};
      `ETH_MGMT_REG_MDIO_WDATA: rd_mux = {16'h0, mdio_wdata_q};
      `ETH_MGMT_REG_MDIO_RDATA: rd_mux = {16'h0, stat_i.rdata};
      `ETH_MGMT_REG_MDIO_CTRL:  rd_mux = {29'h0, stat_i.init, mdio_en_q, stat_i.busy};
      // Unmapped space reads zero
      default:                  rd_mux = '0;
    endcase
  end

  //============================
  // Write decode
  //============================
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      for (int i = 0; i < 4; i++) begin
        scratch_q[i] <= '0;
      end
      mdio_op_q    <= 1'b0;
      phy_addr_q   <= `ETH_MGMT_MDIO_PHY_RST;
      reg_addr_q   <= '0;
      mdio_wdata_q <= '0;
      mdio_en_q    <= 1'b1;
      start_q      <= 1'b0;
      rd_done_q    <= 1'b0;
    end else begin
      rd_done_q <= req_i.rd;
      start_q   <= 1'b0;
      if (req_i.wr) begin
        case (req_i.idx)
          `ETH_MGMT_REG_SCRATCH0: scratch_q[0] <= req_i.wdata;
          `ETH_MGMT_REG_SCRATCH1: scratch_q[1] <= req_i.wdata;
          `ETH_MGMT_REG_SCRATCH2: scratch_q[2] <= req_i.wdata;
          `ETH_MGMT_REG_SCRATCH3: scratch_q[3] <= req_i.wdata;
          `ETH_MGMT_REG_MDIO_ADDR: begin
            mdio_op_q  <= req_i.wdata[10];
            phy_addr_q <= req_i.wdata[9:5];
            reg_addr_q <= req_i.wdata[4:0];
          end
          `ETH_MGMT_REG_MDIO_WDATA: mdio_wdata_q <= req_i.wdata[15:0];
          `ETH_MGMT_REG_MDIO_CTRL: begin
            // Start only honoured with the enable already set
            mdio_en_q <= req_i.wdata[1];
            start_q   <= mdio_en_q & req_i.wdata[0];
          end
          default: ;
        endcase
      end
    end
  end

  // Read data held until the next read
  always_ff @(posedge s_axi_aclk) begin
    if (req_i.rd) begin
      rdata_q <= rd_mux;
    end
  end

  assign rsp_o = '{rd_done: rd_done_q, rdata: rdata_q};

  assign cmd_o = '{start:    start_q,
                   op:       mdio_op_q,
                   phy_addr: phy_addr_q,
                   reg_addr: reg_addr_q,
                   wdata:    mdio_wdata_q};

endmodule

`default_nettype wire

// File: hw/mdio_master.sv
//============================
// MDIO clause 22 master
// MDC generation, init toggling and frame shifting
//============================
`timescale 1ns/100ps
`default_nettype none

`include "eth_mgmt_config.svh"

module mdio_master (
  input  logic                     s_axi_aclk,
  input  logic                     s_axi_aresetn,
  input  eth_mgmt_pkg::mdio_cmd_t  cmd_i,
  output eth_mgmt_pkg::mdio_stat_t stat_o,
  input  logic                     phy_mdio_i,
  output logic                     phy_mdio_o,
  output logic                     phy_mdio_t,
  output logic                     phy_mdc
);

  eth_mgmt_pkg::mdio_cnt_t  cnt_q;
  eth_mgmt_pkg::mdio_data_t rdata_q;
  eth_mgmt_pkg::mdio_data_t tx_data;
  logic [32:0]              frame_q;
  logic                     busy_q;
  logic                     init_q;
  logic                     op_q;
  logic                     start;
  logic                     mdc_fall;
  logic                     frame_end;
  logic                     init_end;
  logic                     rx_bit;

  // New command dropped while a frame or init is running
  assign start     = cmd_i.start & ~busy_q & ~init_q;
  assign frame_end = busy_q & (cnt_q >= `ETH_MGMT_MDIO_CNT_FRAME);
  assign init_end  = init_q & (cnt_q >= `ETH_MGMT_MDIO_CNT_INIT);

  // Odd count means MDC falls on the next edge
  assign mdc_fall  = busy_q & cnt_q[0];

  // Read data sampled in MDC cycles 17 to 32
  assign rx_bit    = mdc_fall & op_q & (cnt_q[6:1] > 16);

  assign tx_data   = cmd_i.op ? '0 : cmd_i.wdata;

  //============================
  // Counter and flags
  //============================
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      cnt_q      <= '0;
      busy_q     <= 1'b0;
      init_q     <= 1'b1;
      op_q       <= 1'b0;
      rdata_q    <= '0;
      phy_mdio_o <= 1'b1;
    end else begin
      if (init_end) begin
        init_q <= 1'b0;
      end

      if (start) begin
        busy_q <= 1'b1;
        op_q   <= cmd_i.op;
      end else if (frame_end) begin
        busy_q <= 1'b0;
      end

      if (init_end || frame_end) begin
        cnt_q <= '0;
      end else if (init_q || busy_q) begin
        cnt_q <= cnt_q + 1'b1;
      end

      if (mdc_fall) begin
        phy_mdio_o <= frame_q[32];
      end

      // MSB first from the PHY
      if (rx_bit) begin
        rdata_q <= {rdata_q[14:0], phy_mdio_i};
      end
    end
  end

  //============================
  // Frame shifter
  //============================
  // Preamble end, op, addresses, turnaround, data, idle bit
  always_ff @(posedge s_axi_aclk) begin
    if (start) begin
      frame_q <= {2'b01, cmd_i.op, ~cmd_i.op, cmd_i.phy_addr, cmd_i.reg_addr,
                  2'b10, tx_data, 1'b1};
    end else if (mdc_fall) begin
      frame_q <= {frame_q[31:0], 1'b1};
    end
  end

  // High releases the line to the PHY
  assign phy_mdio_t = busy_q & op_q & (cnt_q > `ETH_MGMT_MDIO_TRI_CNT);
  assign phy_mdc    = cnt_q[0];

  assign stat_o = '{busy: busy_q, init: init_q, rdata: rdata_q};

endmodule

`default_nettype wire

// File: hw/eth_mgmt_top.sv
//============================
// Ethernet management top
// AXI4-Lite slave, register file and MDIO master
//============================
`timescale 1ns/100ps
`default_nettype none

`include "eth_mgmt_config.svh"

module eth_mgmt_top (
  input  logic                              s_axi_aclk,
  input  logic                              s_axi_aresetn,
  input  logic [`ETH_MGMT_AXI_ADDR_W-1:0]   s_axi_awaddr,
  input  logic                              s_axi_awvalid,
  output logic                              s_axi_awready,
  input  logic [`ETH_MGMT_DATA_W-1:0]       s_axi_wdata,
  // Byte strobes not supported, full-word writes only
  input  logic [`ETH_MGMT_DATA_W/8-1:0]     s_axi_wstrb,
  input  logic                              s_axi_wvalid,
  output logic                              s_axi_wready,
  output logic [1:0]                        s_axi_bresp,
  output logic                              s_axi_bvalid,
  input  logic                              s_axi_bready,
  input  logic [`ETH_MGMT_AXI_ADDR_W-1:0]   s_axi_araddr,
  input  logic                              s_axi_arvalid,
  output logic                              s_axi_arready,
  output logic [`ETH_MGMT_DATA_W-1:0]       s_axi_rdata,
  output logic [1:0]                        s_axi_rresp,
  output logic                              s_axi_rvalid,
  input  logic                              s_axi_rready,
  input  logic                              phy_mdio_i,
  output logic                              phy_mdio_o,
  output logic                              phy_mdio_t,
  output logic                              phy_mdc,
  output logic                              phy_rst_n
);

  eth_mgmt_pkg::reg_req_t   reg_req;
  eth_mgmt_pkg::reg_rsp_t   reg_rsp;
  eth_mgmt_pkg::mdio_cmd_t  mdio_cmd;
  eth_mgmt_pkg::mdio_stat_t mdio_stat;

  eth_mgmt_axi_slave u_axi_slave (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .req_o         (reg_req),
    .rsp_i         (reg_rsp)
  );

  eth_mgmt_regs u_regs (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .req_i         (reg_req),
    .rsp_o         (reg_rsp),
    .cmd_o         (mdio_cmd),
    .stat_i        (mdio_stat)
  );

  mdio_master u_mdio (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .cmd_i         (mdio_cmd),
    .stat_o        (mdio_stat),
    .phy_mdio_i    (phy_mdio_i),
    .phy_mdio_o    (phy_mdio_o),
    .phy_mdio_t    (phy_mdio_t),
    .phy_mdc       (phy_mdc)
  );

  // PHY held in reset with the bus
  assign phy_rst_n = s_axi_aresetn;

endmodule

`default_nettype wire

// File: bench/eth_mgmt_tb.sv
//============================
// Ethernet management testbench
// AXI register access, PHY model and MDIO frame checks
//============================
`timescale 1ns/100ps
`default_nettype none

`include "eth_mgmt_config.svh"

module eth_mgmt_tb;

  // Six tests, each at most init (126) plus a frame (66) plus ~40 bus cycles, with margin
  localparam int WATCHDOG_CYCLES = 2000;

  logic                            s_axi_aclk;
  logic                            s_axi_aresetn;
  logic [`ETH_MGMT_AXI_ADDR_W-1:0] s_axi_awaddr;
  logic                            s_axi_awvalid;
  logic                            s_axi_awready;
  logic [`ETH_MGMT_DATA_W-1:0]     s_axi_wdata;
  logic [`ETH_MGMT_DATA_W/8-1:0]   s_axi_wstrb;
  logic                            s_axi_wvalid;
  logic                            s_axi_wready;
  logic [1:0]                      s_axi_bresp;
  logic                            s_axi_bvalid;
  logic                            s_axi_bready;
  logic [`ETH_MGMT_AXI_ADDR_W-1:0] s_axi_araddr;
  logic                            s_axi_arvalid;
  logic                            s_axi_arready;
  logic [`ETH_MGMT_DATA_W-1:0]     s_axi_rdata;
  logic [1:0]                      s_axi_rresp;
  logic                            s_axi_rvalid;
  logic                            s_axi_rready;
  logic                            phy_mdio_i;
  logic                            phy_mdio_o;
  logic                            phy_mdio_t;
  logic                            phy_mdc;
  logic                            phy_rst_n;
  logic                            mdio_busy;

  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_err0 = 0;
  int          frames_done = 0;
  string       cur_test = "none";
  logic [32:0] frame_exp = '0;
  logic        frame_op = 1'b0;
  logic [15:0] phy_value = '0;
  logic [33:0] line_bits;
  int          line_cnt;
  int          half_cnt;
  logic        busy_seen = 1'b0;
  logic        mdc_seen = 1'b0;

  eth_mgmt_top uut (.*);

  assign mdio_busy = uut.u_mdio.busy_q;

  initial begin
    s_axi_aclk = 1'b0;
    forever #50 s_axi_aclk = ~s_axi_aclk;
  end

  //============================
  // Reference and helpers
  //============================
  // Line level for MDC cycles 0 to 32, cycle 0 in the MSB
  function automatic logic [32:0] expected_frame(input logic op, input logic [4:0] phy,
                                                 input logic [4:0] regad, input logic [15:0] wd);
    logic [32:0] f;
    logic        b;
    f = '0;
    for (int n = 0; n <= 32; n++) begin
      if (n == 0) b = 1'b0;
      else if (n == 1) b = 1'b1;
      else if (n == 2) b = op;
      else if (n == 3) b = ~op;
      else if (n <= 8) b = phy[8-n];
      else if (n <= 13) b = regad[13-n];
      else if (n == 14) b = 1'b1;
      else if (n == 15) b = 1'b0;
      else if (n <= 31) b = op ? 1'b0 : wd[31-n];
      else b = 1'b1;
      f[32-n] = b;
    end
    return f;
  endfunction

  function automatic logic [`ETH_MGMT_AXI_ADDR_W-1:0] byte_addr(input int idx);
    return idx * 4;
  endfunction

  task automatic tick();
    @(posedge s_axi_aclk);
    #10;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic axi_write(input logic [`ETH_MGMT_AXI_ADDR_W-1:0] addr, input logic [31:0] data);
    s_axi_awaddr  = addr;
    s_axi_awvalid = 1'b1;
    s_axi_wdata   = data;
    s_axi_wvalid  = 1'b1;
    while (!(s_axi_awready && s_axi_wready)) tick();
    tick();
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    check_value("awready low", 0, s_axi_awready);
    check_value("wready low", 0, s_axi_wready);
    s_axi_bready  = 1'b1;
    while (!s_axi_bvalid) tick();
    check_value("bresp", 0, s_axi_bresp);
    tick();
    s_axi_bready = 1'b0;
    check_value("bvalid cleared", 0, s_axi_bvalid);
    check_value("awready back", 1, s_axi_awready);
    check_value("wready back", 1, s_axi_wready);
  endtask

  // Hold keeps rready low for that many cycles once rvalid is up
  task automatic axi_read(input logic [`ETH_MGMT_AXI_ADDR_W-1:0] addr, input int hold,
                          output logic [31:0] data);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    while (!s_axi_arready) tick();
    tick();
    s_axi_arvalid = 1'b0;
    while (!s_axi_rvalid) tick();
    data = s_axi_rdata;
    check_value("rresp", 0, s_axi_rresp);
    for (int i = 0; i < hold; i++) begin
      tick();
      check_value("rvalid held", 1, s_axi_rvalid);
      check_value("rdata held", data, s_axi_rdata);
      check_value("arready low", 0, s_axi_arready);
    end
    s_axi_rready = 1'b1;
    tick();
    s_axi_rready = 1'b0;
    check_value("rvalid cleared", 0, s_axi_rvalid);
    check_value("arready back", 1, s_axi_arready);
  endtask

  task automatic wait_mdio_idle();
    logic [31:0] ctrl;
    int          polls;
    ctrl  = 32'h1;
    polls = 0;
    while (ctrl[0] && polls < 40) begin
      axi_read(byte_addr(`ETH_MGMT_REG_MDIO_CTRL), 0, ctrl);
      polls++;
    end
    assert (!ctrl[0]) else begin
      $display("ERROR: %s: MDIO busy still set after %0d polls", cur_test, polls);
      errors++;
    end
    check_value("ctrl after frame", 32'h2, ctrl);
  endtask

  task automatic run_frame(input logic op, input logic [4:0] phy, input logic [4:0] regad,
                           input logic [15:0] wd);
    logic [31:0] rd;
    int          n0;
    axi_write(byte_addr(`ETH_MGMT_REG_MDIO_ADDR), {21'h0, op, phy, regad});
    axi_write(byte_addr(`ETH_MGMT_REG_MDIO_WDATA), {16'h0, wd});
    axi_read(byte_addr(`ETH_MGMT_REG_MDIO_ADDR), 0, rd);
    check_value("mdio addr", {21'h0, op, phy, regad}, rd);
    frame_exp = expected_frame(op, phy, regad, wd);
    frame_op  = op;
    n0        = frames_done;
    axi_write(byte_addr(`ETH_MGMT_REG_MDIO_CTRL), 32'h3);
    wait_mdio_idle();
    check_value("frames seen", n0 + 1, frames_done);
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != test_err0) tests_failed++;
    $display("[tb] test %-12s %s (%0d errors)", cur_test,
             (errors == test_err0) ? "ok" : "FAILED", errors - test_err0);
  endtask

  //============================
  // PHY model and frame checker
  //============================
  // Drives read data on falling MDC, bit k held through MDC cycle 17+k
  initial begin : phy_responder
    logic mdc_q;
    int   rises;
    phy_mdio_i = 1'b1;
    mdc_q      = 1'b0;
    rises      = 0;
    forever begin
      tick();
      if (!mdio_busy) begin
        rises      = 0;
        phy_mdio_i = 1'b1;
      end else if (phy_mdc && !mdc_q) begin
        rises++;
      end else if (!phy_mdc && mdc_q) begin
        phy_mdio_i = (rises >= 17 && rises <= 32) ? phy_value[32-rises] : 1'b1;
      end
      mdc_q = phy_mdc;
    end
  end

  // Line moves at falling MDC, so the first rising edge still sees idle
  always @(negedge s_axi_aclk) begin
    if (mdio_busy) begin
      if (!busy_seen) begin
        line_bits = '0;
        line_cnt  = 0;
        half_cnt  = 0;
      end
      if (phy_mdc && !mdc_seen) begin
        line_bits = {line_bits[32:0], phy_mdio_o};
        line_cnt++;
      end
      assert (phy_mdio_t === (frame_op && half_cnt > `ETH_MGMT_MDIO_TRI_CNT)) else begin
        $display("ERROR: %s: wrong data line direction at half-MDC count %0d",
                 cur_test, half_cnt);
        errors++;
      end
      half_cnt++;
    end else begin
      if (busy_seen) begin
        line_bits = {line_bits[32:0], phy_mdio_o};
        line_cnt++;
        assert (line_cnt == 34 && line_bits === {1'b1, frame_exp}) else begin
          $display("MISMATCH %s mdio line: expected %h, actual %h (%0d samples)",
                   cur_test, {1'b1, frame_exp}, line_bits, line_cnt);
          errors++;
        end
        frames_done++;
      end
      assert (phy_mdio_t === 1'b0) else begin
        $display("ERROR: %s: data line released with no frame running", cur_test);
        errors++;
      end
    end
    busy_seen = mdio_busy;
    mdc_seen  = phy_mdc;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge s_axi_aclk);
    $display("ERROR: run did not finish within %0d cycles, stuck in test %s",
             WATCHDOG_CYCLES, cur_test);
    $display("Simulation failed");
    $finish;
  end

  //============================
  // Tests
  //============================
  initial begin : main
    logic [31:0] rd;
    logic [31:0] words [4];
    logic [31:0] rnd;
    void'($urandom(32'h81e6));
    s_axi_aresetn = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '1;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;

    begin_test("reset");
    repeat (3) @(posedge s_axi_aclk);
    #10;
    check_value("phy_rst_n in reset", 0, phy_rst_n);
    s_axi_aresetn = 1'b1;
    tick();
    check_value("phy_rst_n", 1, phy_rst_n);
    axi_read(byte_addr(`ETH_MGMT_REG_MDIO_ADDR), 0, rd);
    check_value("mdio addr", 32'h20, rd);
    axi_read(byte_addr(`ETH_MGMT_REG_MDIO_CTRL), 0, rd);
    check_value("ctrl init", 32'h6, rd);
    repeat (126) tick();
    axi_read(byte_addr(`ETH_MGMT_REG_MDIO_CTRL), 0, rd);
    check_value("ctrl after init", 32'h2, rd);
    axi_read(byte_addr(16), 0, rd);
    check_value("index 16", 0, rd);
    axi_read(byte_addr(300), 0, rd);
    check_value("index 300", 0, rd);
    end_test();

    begin_test("scratch");
    for (int i = 0; i < 4; i++) begin
      words[i] = $urandom;
      axi_write(byte_addr(i), words[i]);
    end
    axi_write(byte_addr(16), $urandom);
    for (int i = 0; i < 4; i++) begin
      axi_read(byte_addr(i), 0, rd);
      check_value($sformatf("scratch%0d", i), words[i], rd);
    end
    axi_read(byte_addr(16), 0, rd);
    check_value("index 16", 0, rd);
    end_test();

    begin_test("mdio_write");
    rnd = $urandom;
    run_frame(1'b0, rnd[4:0], rnd[9:5], rnd[31:16]);
    end_test();

    begin_test("mdio_read");
    rnd       = $urandom;
    phy_value = rnd[31:16];
    run_frame(1'b1, rnd[4:0], rnd[9:5], 16'hffff);
    axi_read(byte_addr(`ETH_MGMT_REG_MDIO_RDATA), 0, rd);
    check_value("read data", {16'h0, phy_value}, rd);
    end_test();

    begin_test("enable");
    axi_write(byte_addr(`ETH_MGMT_REG_MDIO_CTRL), 32'h0);
    axi_read(byte_addr(`ETH_MGMT_REG_MDIO_CTRL), 0, rd);
    check_value("ctrl disabled", 0, rd);
    axi_write(byte_addr(`ETH_MGMT_REG_MDIO_CTRL), 32'h1);
    for (int i = 0; i < 20; i++) begin
      tick();
      check_value("mdc idle", 0, phy_mdc);
    end
    axi_read(byte_addr(`ETH_MGMT_REG_MDIO_CTRL), 0, rd);
    check_value("ctrl no start", 0, rd);
    axi_write(byte_addr(`ETH_MGMT_REG_MDIO_CTRL), 32'h2);
    rnd = $urandom;
    run_frame(1'b0, rnd[4:0], rnd[9:5], rnd[31:16]);
    end_test();

    begin_test("backpressure");
    words[2] = $urandom;
    axi_write(byte_addr(2), words[2]);
    axi_read(byte_addr(2), 6, rd);
    check_value("scratch2", words[2], rd);
    end_test();

    $display("[tb] %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: eth_mgmt_top.f
+incdir+include
hw/eth_mgmt_pkg.sv
hw/eth_mgmt_axi_slave.sv
hw/eth_mgmt_regs.sv
hw/mdio_master.sv
hw/eth_mgmt_top.sv
bench/eth_mgmt_tb.sv
